//--- dv/memory_unit_checker.sv
// Bus and peripheral protocol assertions for the memory unit.
// Bound into every memory_unit instance by the bind at the end of this file.
// A failure raises $error and is counted in fail_count.

`timescale 1ns/1ns

module memory_unit_checker (
    input logic                     clk,
    input logic                     reset,
    input mu_bus_pkg::bus_req_t     i_bus,
    input mu_bus_pkg::bus_rsp_t     i_rsp,
    input mu_bus_pkg::io_sel_e      i_sel,
    input mu_periph_pkg::spi_pins_t i_spi1,
    input mu_periph_pkg::spi_pins_t i_spi3,
    input logic                     i_spi1_busy,
    input logic                     i_spi3_busy,
    input logic                     i_ost_int
);
    import mu_bus_pkg::*;
    import mu_periph_pkg::*;

    int   fail_count = 0;
    logic spi_data_write;
    logic reg_start;

    // Everything but an SPI data write is a fixed-latency register access
    assign spi_data_write = i_bus.we && (i_sel == SEL_SPI1_DATA || i_sel == SEL_SPI3_DATA);
    assign reg_start      = i_bus.start && !spi_data_write;

    // --------------------------------------
    // Bus response
    // --------------------------------------
    done_one_cycle: assert property (@(posedge clk) disable iff (reset)
        i_rsp.done |=> !i_rsp.done)
    else
    begin
        $error("Bus done stayed high for two cycles");
        fail_count++;
    end

    reg_latency: assert property (@(posedge clk) disable iff (reset)
        reg_start |=> !i_rsp.done ##1 i_rsp.done)
    else
    begin
        $error("Register access did not end in done two cycles after start");
        fail_count++;
    end

    // --------------------------------------
    // Peripherals
    // --------------------------------------
    spi1_sclk_idle: assert property (@(posedge clk) disable iff (reset)
        !i_spi1_busy |-> !i_spi1.sclk)
    else
    begin
        $error("SPI1 sclk high while the channel is idle");
        fail_count++;
    end

    spi3_sclk_idle: assert property (@(posedge clk) disable iff (reset)
        !i_spi3_busy |-> !i_spi3.sclk)
    else
    begin
        $error("SPI3 sclk high while the channel is idle");
        fail_count++;
    end

    ost_int_pulse: assert property (@(posedge clk) disable iff (reset)
        i_ost_int |=> !i_ost_int)
    else
    begin
        $error("OS timer interrupt longer than one cycle");
        fail_count++;
    end

endmodule

bind memory_unit memory_unit_checker chk0 (
    .clk         (clk),
    .reset       (reset),
    .i_bus       (i_bus),
    .i_rsp       (o_bus),
    .i_sel       (sel),
    .i_spi1      (o_spi1),
    .i_spi3      (o_spi3),
    .i_spi1_busy (spi1_master.busy),
    .i_spi3_busy (spi3_master.busy),
    .i_ost_int   (o_ost_int)
);

//--- dv/tb_memory_unit.sv
// Testbench for the memory-mapped I/O block.
// Drives the CPU bus through chip-select, SPI loopback, GPIO, timer and
// status accesses and checks each read against the register rules.
// Bus timing and pulse widths are watched by the bound checker.

`timescale 1ns/1ns

module tb_memory_unit;
    import mu_bus_pkg::*;
    import mu_periph_pkg::*;

    localparam int MAX_CYCLES = 3000;
    localparam int SPI_ROUNDS = 8;

    logic              clk;
    logic              reset;
    bus_req_t          bus_req;
    bus_rsp_t          bus_rsp;
    spi_pins_t         spi1_pins;
    spi_pins_t         spi3_pins;
    logic              spi1_nint;
    logic              spi3_int;
    logic [GPIO_W-1:0] gpi;
    logic [GPIO_W-1:0] gpo;
    logic              ost_int;
    logic              boot_mode;
    logic [31:0]       rng_state;
    logic [GPIO_W-1:0] gpo_model;
    int                cycle = 0;
    int                int_edges[$];
    int                spi1_rises = 0;
    int                spi3_rises = 0;

    // MISO of each channel looped back from its MOSI
    memory_unit #(
        .SPI1_HALF_BIT (2),
        .SPI3_HALF_BIT (1)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .i_bus       (bus_req),
        .o_bus       (bus_rsp),
        .o_spi1      (spi1_pins),
        .o_spi3      (spi3_pins),
        .i_spi1_miso (spi1_pins.mosi),
        .i_spi1_nint (spi1_nint),
        .i_spi3_miso (spi3_pins.mosi),
        .i_spi3_int  (spi3_int),
        .i_gpi       (gpi),
        .o_gpo       (gpo),
        .o_ost_int   (ost_int),
        .i_boot_mode (boot_mode)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    // Number of the edge that samples each timer pulse
    always @(negedge clk)
    begin
        if (ost_int === 1'b1)
            int_edges.push_back(cycle + 1);
    end

    // Rising SCLK edges seen on each channel
    always @(posedge spi1_pins.sclk)
        spi1_rises++;

    always @(posedge spi3_pins.sclk)
        spi3_rises++;

    always @(negedge clk)
    begin
        if (cycle >= MAX_CYCLES)
            stop_with_failure($sformatf("Timeout: test still running after %0d cycles",
                                        MAX_CYCLES));
        else if (dut0.chk0.fail_count != 0)
            stop_with_failure("A protocol assertion in the checker failed");
    end

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped on the first failure");
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else
            stop_with_failure($sformatf("ERR %s: got 0x%08h, expected 0x%08h",
                                        name, got, exp));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng_state = xorshift32(rng_state);
        r = rng_state;
    endtask

    function automatic int sclk_rises(input logic [BUS_ADDR_W-1:0] addr);
        return (addr == ADDR_SPI1_DATA) ? spi1_rises : spi3_rises;
    endfunction

    // New GPI, boot-mode and interrupt levels
    task automatic set_status_inputs;
        logic [31:0] r;
        draw_random(r);
        @(posedge clk);
        #1;
        gpi       = r[3:0];
        boot_mode = r[4];
        spi1_nint = r[5];
        spi3_int  = r[6];
    endtask

    // --------------------------------------
    // Bus accesses
    // --------------------------------------
    // One start strobe, then wait for done; latency counts cycles to done
    task automatic issue_access(input logic [BUS_ADDR_W-1:0] addr,
                                input logic [BUS_DATA_W-1:0] data, input logic we,
                                output logic [BUS_DATA_W-1:0] q,
                                output int start_edge, output int latency);
        @(posedge clk);
        #1;
        bus_req.addr  = addr;
        bus_req.data  = data;
        bus_req.we    = we;
        bus_req.start = 1'b1;
        @(posedge clk);
        #1;
        bus_req.start = 1'b0;
        start_edge    = cycle;
        latency       = 0;
        do
        begin
            @(negedge clk);
            latency++;
        end
        while (bus_rsp.done !== 1'b1);
        q = bus_rsp.q;
    endtask

    task automatic write_reg(input logic [BUS_ADDR_W-1:0] addr,
                             input logic [BUS_DATA_W-1:0] data);
        logic [BUS_DATA_W-1:0] q;
        int                    s_edge;
        int                    lat;
        issue_access(addr, data, 1'b1, q, s_edge, lat);
    endtask

    task automatic read_reg(input logic [BUS_ADDR_W-1:0] addr,
                            output logic [BUS_DATA_W-1:0] q);
        int s_edge;
        int lat;
        issue_access(addr, '0, 1'b0, q, s_edge, lat);
    endtask

    task automatic wait_until_cycle(input int target);
        while (cycle < target)
            @(negedge clk);
    endtask

    // --------------------------------------
    // Test sequences
    // --------------------------------------
    task automatic check_reset_state;
        logic [31:0] q;
        expect_equal("o_spi1.cs_n", spi1_pins.cs_n, 1);
        expect_equal("o_spi3.cs_n", spi3_pins.cs_n, 1);
        expect_equal("o_gpo", gpo, 0);
        expect_equal("o_ost_int", ost_int, 0);
        expect_equal("o_bus.done", bus_rsp.done, 0);
        expect_equal("o_bus.q", bus_rsp.q, 0);
        read_reg(ADDR_GPIO, q);
        expect_equal("o_bus.q (GPIO)", q, {28'h0, gpi});
    endtask

    task automatic check_chip_selects;
        logic [31:0] r;
        logic [31:0] q;
        for (int ch = 0; ch < 2; ch++)
        begin
            for (int v = 0; v < 2; v++)
            begin
                draw_random(r);
                // Only data bit 0 reaches the chip select
                write_reg(ch == 0 ? ADDR_SPI1_CS : ADDR_SPI3_CS, {r[31:1], v[0]});
                if (ch == 0)
                    expect_equal("o_spi1.cs_n", spi1_pins.cs_n, v);
                else
                    expect_equal("o_spi3.cs_n", spi3_pins.cs_n, v);
                read_reg(ch == 0 ? ADDR_SPI1_CS : ADDR_SPI3_CS, q);
                expect_equal("o_bus.q (CS)", q, v);
            end
        end
    endtask

    task automatic check_spi_loopback(input logic [BUS_ADDR_W-1:0] addr, input string name,
                                      input string sclk_name);
        logic [31:0] r;
        logic [31:0] q;
        int          rises_before;
        repeat (SPI_ROUNDS)
        begin
            draw_random(r);
            rises_before = sclk_rises(addr);
            write_reg(addr, r);
            // One SCLK pulse per bit of the byte
            expect_equal(sclk_name, sclk_rises(addr) - rises_before, SPI_BYTE_W);
            read_reg(addr, q);
            expect_equal(name, q, {24'h0, r[7:0]});
        end
    endtask

    task automatic check_gpio;
        logic [31:0] r;
        logic [31:0] q;
        repeat (6)
        begin
            set_status_inputs();
            draw_random(r);
            write_reg(ADDR_GPIO, r);
            gpo_model = r[7:4];
            expect_equal("o_gpo", gpo, gpo_model);
            read_reg(ADDR_GPIO, q);
            expect_equal("o_bus.q (GPIO)", q, {24'h0, gpo_model, gpi});
        end
    endtask

    // Pulse is due N+2 edges after the edge that samples the last trigger
    task automatic run_timer_case(input logic retrigger);
        logic [31:0] r;
        logic [31:0] q;
        int          n;
        int          s_edge;
        int          lat;
        draw_random(r);
        n = retrigger ? 8 + int'(r[3:0]) : 1 + int'(r[3:0]);
        write_reg(ADDR_TIMER_VAL, n);
        int_edges.delete();
        issue_access(ADDR_TIMER_CTRL, r, 1'b1, q, s_edge, lat);
        if (retrigger)
            issue_access(ADDR_TIMER_CTRL, r, 1'b1, q, s_edge, lat);
        wait_until_cycle(s_edge + n + 4);
        expect_equal("o_ost_int pulse count", int_edges.size(), 1);
        expect_equal("o_ost_int sampling edge", int_edges[0], s_edge + n + 2);
    endtask

    task automatic check_status_reads;
        logic [BUS_ADDR_W-1:0] unmapped [4];
        logic [31:0]           r;
        logic [31:0]           q;
        int                    s_edge;
        int                    lat;
        unmapped[0] = 27'hC0272A;
        unmapped[1] = 27'hC02734;
        unmapped[2] = 27'hC02740;
        unmapped[3] = 27'h0000100;
        read_reg(ADDR_TIMER_VAL, q);
        expect_equal("o_bus.q (TIMER_VAL)", q, 0);
        read_reg(ADDR_TIMER_CTRL, q);
        expect_equal("o_bus.q (TIMER_CTRL)", q, 0);
        for (int i = 0; i < 4; i++)
        begin
            set_status_inputs();
            read_reg(ADDR_SPI1_NINT, q);
            expect_equal("o_bus.q (SPI1 NINT)", q, spi1_nint);
            read_reg(ADDR_SPI3_INT, q);
            expect_equal("o_bus.q (SPI3 INT)", q, spi3_int);
            read_reg(ADDR_BOOTMODE, q);
            expect_equal("o_bus.q (boot mode)", q, boot_mode);
            issue_access(unmapped[i], '0, 1'b0, q, s_edge, lat);
            expect_equal("o_bus.q (unmapped)", q, 0);
            expect_equal("o_bus.done latency (unmapped read)", lat, 2);
            draw_random(r);
            issue_access(unmapped[i], r, 1'b1, q, s_edge, lat);
            expect_equal("o_bus.done latency (unmapped write)", lat, 2);
        end
    endtask

    // --------------------------------------
    // Main sequence
    // --------------------------------------
    initial
    begin
        logic [31:0] r;
        rng_state = 32'haa8be07c;
        reset     = 1'b1;
        bus_req   = '0;
        gpo_model = '0;
        draw_random(r);
        gpi       = r[3:0];
        boot_mode = r[4];
        spi1_nint = r[5];
        spi3_int  = r[6];
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);

        check_reset_state();
        check_chip_selects();
        check_spi_loopback(ADDR_SPI1_DATA, "o_bus.q (SPI1 data)", "o_spi1.sclk rising edges");
        check_spi_loopback(ADDR_SPI3_DATA, "o_bus.q (SPI3 data)", "o_spi3.sclk rising edges");
        check_gpio();
        run_timer_case(1'b0);
        run_timer_case(1'b0);
        run_timer_case(1'b1);
        check_status_reads();

        // Last done pulse still has its checker cycle ahead
        repeat (2) @(negedge clk);

        if (dut0.chk0.fail_count != 0)
            stop_with_failure("A protocol assertion in the checker failed");
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- hdl/io_addr_decoder.sv
// Address decoder for the I/O register window.
// Purely combinational; any address outside the map selects SEL_NONE,
// which the bus controller answers with a zero read.

`timescale 1ns/1ns

module io_addr_decoder (
    input  logic [mu_bus_pkg::BUS_ADDR_W-1:0] i_addr,
    output mu_bus_pkg::io_sel_e               o_sel
);
    import mu_bus_pkg::*;

    always_comb
    begin
        case (i_addr)
            ADDR_SPI1_DATA:  o_sel = SEL_SPI1_DATA;
            ADDR_SPI1_CS:    o_sel = SEL_SPI1_CS;
            ADDR_SPI1_NINT:  o_sel = SEL_SPI1_NINT;
            ADDR_SPI3_DATA:  o_sel = SEL_SPI3_DATA;
            ADDR_SPI3_CS:    o_sel = SEL_SPI3_CS;
            ADDR_SPI3_INT:   o_sel = SEL_SPI3_INT;
            ADDR_GPIO:       o_sel = SEL_GPIO;
            ADDR_TIMER_VAL:  o_sel = SEL_TIMER_VAL;
            ADDR_TIMER_CTRL: o_sel = SEL_TIMER_CTRL;
            ADDR_BOOTMODE:   o_sel = SEL_BOOTMODE;
            default:         o_sel = SEL_NONE;
        endcase
    end

endmodule

//--- hdl/io_bus_controller.sv
// Bus transaction controller of the I/O window.
// Accepts one access per start strobe, performs register writes and peripheral
// strobes, then answers with a one-cycle done and a latched read word.
// Register accesses finish two cycles after start; SPI data writes finish
// one cycle after the selected channel reports its byte done.

`timescale 1ns/1ns

module io_bus_controller (
    input  logic                                 clk,
    input  logic                                 reset,
    input  mu_bus_pkg::bus_req_t                 i_bus,
    input  mu_bus_pkg::io_sel_e                  i_sel,
    input  logic [mu_periph_pkg::SPI_BYTE_W-1:0] i_spi1_rx,
    input  logic                                 i_spi1_done,
    input  logic [mu_periph_pkg::SPI_BYTE_W-1:0] i_spi3_rx,
    input  logic                                 i_spi3_done,
    input  logic                                 i_spi1_nint,
    input  logic                                 i_spi3_int,
    input  logic [mu_periph_pkg::GPIO_W-1:0]     i_gpi,
    input  logic                                 i_boot_mode,
    output logic                                 o_spi1_start,
    output logic                                 o_spi3_start,
    output logic [mu_periph_pkg::SPI_BYTE_W-1:0] o_spi_tx_byte,
    output logic                                 o_spi1_cs_n,
    output logic                                 o_spi3_cs_n,
    output logic [mu_periph_pkg::GPIO_W-1:0]     o_gpo,
    output logic                                 o_timer_load,
    output logic                                 o_timer_trigger,
    output logic [mu_periph_pkg::TIMER_W-1:0]    o_timer_value,
    output mu_bus_pkg::bus_rsp_t                 o_bus
);
    import mu_bus_pkg::*;
    import mu_periph_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        REG_ACK,
        WAIT_SPI,
        DONE
    } ctrl_state_e;

    ctrl_state_e           state;
    bus_rsp_t              rsp;
    logic                  accept;
    logic                  wr_accept;
    logic                  spi_write;
    logic                  spi_done;
    logic                  finish;
    logic [BUS_DATA_W-1:0] rd_data;

    assign accept    = (state == IDLE) && i_bus.start;
    assign wr_accept = accept && i_bus.we;
    assign spi_write = i_bus.we && (i_sel == SEL_SPI1_DATA || i_sel == SEL_SPI3_DATA);
    // Address is held until done, so the select still names the channel
    assign spi_done  = (i_sel == SEL_SPI1_DATA) ? i_spi1_done : i_spi3_done;
    assign finish    = (state == REG_ACK) || (state == WAIT_SPI && spi_done);

    // Peripheral strobes in the accept cycle
    assign o_spi1_start    = wr_accept && (i_sel == SEL_SPI1_DATA);
    assign o_spi3_start    = wr_accept && (i_sel == SEL_SPI3_DATA);
    assign o_spi_tx_byte   = i_bus.data[SPI_BYTE_W-1:0];
    assign o_timer_load    = wr_accept && (i_sel == SEL_TIMER_VAL);
    assign o_timer_trigger = wr_accept && (i_sel == SEL_TIMER_CTRL);
    assign o_timer_value   = i_bus.data[TIMER_W-1:0];
    assign o_bus           = rsp;

    // --------------------------------------
    // Transaction FSM
    // --------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
        end
        else
        begin
            case (state)
                IDLE:
                    if (i_bus.start)
                        state <= spi_write ? WAIT_SPI : REG_ACK;
                REG_ACK:
                    state <= DONE;
                WAIT_SPI:
                    if (spi_done)
                        state <= DONE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    // Chip selects and GPO
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_spi1_cs_n <= 1'b1;
            o_spi3_cs_n <= 1'b1;
            o_gpo       <= '0;
        end
        else if (wr_accept)
        begin
            case (i_sel)
                SEL_SPI1_CS: o_spi1_cs_n <= i_bus.data[0];
                SEL_SPI3_CS: o_spi3_cs_n <= i_bus.data[0];
                SEL_GPIO:    o_gpo       <= i_bus.data[2*GPIO_W-1:GPIO_W];
                default:     ;
            endcase
        end
    end

    // --------------------------------------
    // Read mux and response latch
    // --------------------------------------
    always_comb
    begin
        case (i_sel)
            SEL_SPI1_DATA: rd_data = BUS_DATA_W'(i_spi1_rx);
            SEL_SPI1_CS:   rd_data = BUS_DATA_W'(o_spi1_cs_n);
            SEL_SPI1_NINT: rd_data = BUS_DATA_W'(i_spi1_nint);
            SEL_SPI3_DATA: rd_data = BUS_DATA_W'(i_spi3_rx);
            SEL_SPI3_CS:   rd_data = BUS_DATA_W'(o_spi3_cs_n);
            SEL_SPI3_INT:  rd_data = BUS_DATA_W'(i_spi3_int);
            // GPO sits above GPI
            SEL_GPIO:      rd_data = BUS_DATA_W'({o_gpo, i_gpi});
            SEL_BOOTMODE:  rd_data = BUS_DATA_W'(i_boot_mode);
            default:       rd_data = '0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rsp <= '0;
        end
        else
        begin
            rsp.done <= finish;
            if (finish)
                rsp.q <= rd_data;
        end
    end

endmodule

//--- hdl/memory_unit.sv
// Memory-mapped I/O block of the CPU.
// Two SPI master channels (USB controller on SPI1, Ethernet on SPI3),
// one OS timer, GPO/GPI and the boot-mode input behind one bus port.
// The SPI half-bit dividers are set here and passed to the channels.

`timescale 1ns/1ns

module memory_unit #(
    parameter int SPI1_HALF_BIT = 2,
    parameter int SPI3_HALF_BIT = 1
) (
    input  logic                             clk,
    input  logic                             reset,
    input  mu_bus_pkg::bus_req_t             i_bus,
    output mu_bus_pkg::bus_rsp_t             o_bus,
    output mu_periph_pkg::spi_pins_t         o_spi1,
    output mu_periph_pkg::spi_pins_t         o_spi3,
    input  logic                             i_spi1_miso,
    input  logic                             i_spi1_nint,
    input  logic                             i_spi3_miso,
    input  logic                             i_spi3_int,
    input  logic [mu_periph_pkg::GPIO_W-1:0] i_gpi,
    output logic [mu_periph_pkg::GPIO_W-1:0] o_gpo,
    output logic                             o_ost_int,
    input  logic                             i_boot_mode
);
    import mu_bus_pkg::*;
    import mu_periph_pkg::*;

    io_sel_e               sel;
    logic                  spi1_start;
    logic                  spi3_start;
    logic [SPI_BYTE_W-1:0] spi_tx_byte;
    logic [SPI_BYTE_W-1:0] spi1_rx;
    logic [SPI_BYTE_W-1:0] spi3_rx;
    logic                  spi1_done;
    logic                  spi3_done;
    logic                  spi1_cs_n;
    logic                  spi3_cs_n;
    logic                  spi1_sclk;
    logic                  spi1_mosi;
    logic                  spi3_sclk;
    logic                  spi3_mosi;
    logic                  timer_load;
    logic                  timer_trigger;
    logic [TIMER_W-1:0]    timer_value;

    assign o_spi1 = '{sclk: spi1_sclk, mosi: spi1_mosi, cs_n: spi1_cs_n};
    assign o_spi3 = '{sclk: spi3_sclk, mosi: spi3_mosi, cs_n: spi3_cs_n};

    io_addr_decoder decoder0 (
        .i_addr (i_bus.addr),
        .o_sel  (sel)
    );

    io_bus_controller ctrl0 (
        .clk             (clk),
        .reset           (reset),
        .i_bus           (i_bus),
        .i_sel           (sel),
        .i_spi1_rx       (spi1_rx),
        .i_spi1_done     (spi1_done),
        .i_spi3_rx       (spi3_rx),
        .i_spi3_done     (spi3_done),
        .i_spi1_nint     (i_spi1_nint),
        .i_spi3_int      (i_spi3_int),
        .i_gpi           (i_gpi),
        .i_boot_mode     (i_boot_mode),
        .o_spi1_start    (spi1_start),
        .o_spi3_start    (spi3_start),
        .o_spi_tx_byte   (spi_tx_byte),
        .o_spi1_cs_n     (spi1_cs_n),
        .o_spi3_cs_n     (spi3_cs_n),
        .o_gpo           (o_gpo),
        .o_timer_load    (timer_load),
        .o_timer_trigger (timer_trigger),
        .o_timer_value   (timer_value),
        .o_bus           (o_bus)
    );

    // USB controller channel
    spi_byte_master #(
        .CLKS_PER_HALF_BIT (SPI1_HALF_BIT)
    ) spi1_master (
        .clk       (clk),
        .reset     (reset),
        .i_start   (spi1_start),
        .i_tx_byte (spi_tx_byte),
        .i_miso    (i_spi1_miso),
        .o_sclk    (spi1_sclk),
        .o_mosi    (spi1_mosi),
        .o_rx_byte (spi1_rx),
        .o_done    (spi1_done)
    );

    // Ethernet channel
    spi_byte_master #(
        .CLKS_PER_HALF_BIT (SPI3_HALF_BIT)
    ) spi3_master (
        .clk       (clk),
        .reset     (reset),
        .i_start   (spi3_start),
        .i_tx_byte (spi_tx_byte),
        .i_miso    (i_spi3_miso),
        .o_sclk    (spi3_sclk),
        .o_mosi    (spi3_mosi),
        .o_rx_byte (spi3_rx),
        .o_done    (spi3_done)
    );

    os_timer ost0 (
        .clk       (clk),
        .reset     (reset),
        .i_load    (timer_load),
        .i_trigger (timer_trigger),
        .i_value   (timer_value),
        .o_int     (o_ost_int)
    );

endmodule

//--- hdl/mu_bus_pkg.sv
// CPU-side bus types and the I/O register map of the memory unit.
// Import into any module that decodes addresses or handles bus requests.
// Addresses are word addresses on the 27-bit CPU bus.

package mu_bus_pkg;

    localparam int BUS_ADDR_W = 27;
    localparam int BUS_DATA_W = 32;

    // Request from the CPU, held steady until done
    typedef struct packed {
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] data;
        logic                  we;
        logic                  start;
    } bus_req_t;

    // Response back to the CPU
    typedef struct packed {
        logic [BUS_DATA_W-1:0] q;
        logic                  done;
    } bus_rsp_t;

    // --------------------------------------
    // I/O register window
    // --------------------------------------
    localparam logic [BUS_ADDR_W-1:0] ADDR_SPI1_DATA  = 27'hC0272B;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SPI1_CS    = 27'hC0272C;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SPI1_NINT  = 27'hC0272D;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SPI3_DATA  = 27'hC02731;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SPI3_CS    = 27'hC02732;
    localparam logic [BUS_ADDR_W-1:0] ADDR_SPI3_INT   = 27'hC02733;
    localparam logic [BUS_ADDR_W-1:0] ADDR_GPIO       = 27'hC02737;
    localparam logic [BUS_ADDR_W-1:0] ADDR_TIMER_VAL  = 27'hC02739;
    localparam logic [BUS_ADDR_W-1:0] ADDR_TIMER_CTRL = 27'hC0273A;
    localparam logic [BUS_ADDR_W-1:0] ADDR_BOOTMODE   = 27'hC02741;

    // Register select from the address decoder
    typedef enum logic [3:0] {
        SEL_NONE,
        SEL_SPI1_DATA,
        SEL_SPI1_CS,
        SEL_SPI1_NINT,
        SEL_SPI3_DATA,
        SEL_SPI3_CS,
        SEL_SPI3_INT,
        SEL_GPIO,
        SEL_TIMER_VAL,
        SEL_TIMER_CTRL,
        SEL_BOOTMODE
    } io_sel_e;

endpackage

//--- hdl/mu_periph_pkg.sv
// Pin groups and data widths of the I/O peripherals.
// Used by the SPI masters, the OS timer, the bus controller and the top level.

package mu_periph_pkg;

    localparam int SPI_BYTE_W = 8;
    localparam int TIMER_W    = 32;
    localparam int GPIO_W     = 4;

    // Outgoing pins of one SPI channel
    typedef struct packed {
        logic sclk;
        logic mosi;
        logic cs_n;
    } spi_pins_t;

endpackage

//--- hdl/os_timer.sv
// OS timer: a loadable down-counter with a one-cycle interrupt.
// i_load stores the reload value, i_trigger (re)starts the countdown from it.
// o_int pulses N+1 cycles after the trigger cycle, then the timer stops.

`timescale 1ns/1ns

module os_timer (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              i_load,
    input  logic                              i_trigger,
    input  logic [mu_periph_pkg::TIMER_W-1:0] i_value,
    output logic                              o_int
);
    import mu_periph_pkg::*;

    logic [TIMER_W-1:0] reload;
    logic [TIMER_W-1:0] count;
    logic               running;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload  <= '0;
            count   <= '0;
            running <= 1'b0;
            o_int   <= 1'b0;
        end
        else
        begin
            o_int <= 1'b0;
            if (i_load)
                reload <= i_value;

            // A trigger while counting simply restarts
            if (i_trigger)
            begin
                count   <= reload;
                running <= 1'b1;
            end
            else if (running)
            begin
                if (count == '0)
                begin
                    o_int   <= 1'b1;
                    running <= 1'b0;
                end
                else
                begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/spi_byte_master.sv
// One-byte SPI master, mode 0, MSB first.
// Pulse i_start with the byte on i_tx_byte; o_done pulses one cycle when the
// byte has been shifted out and the received byte is on o_rx_byte.
// SCLK toggles every CLKS_PER_HALF_BIT cycles. Chip select is not handled here.

`timescale 1ns/1ns

module spi_byte_master #(
    parameter int CLKS_PER_HALF_BIT = 2
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 i_start,
    input  logic [mu_periph_pkg::SPI_BYTE_W-1:0] i_tx_byte,
    input  logic                                 i_miso,
    output logic                                 o_sclk,
    output logic                                 o_mosi,
    output logic [mu_periph_pkg::SPI_BYTE_W-1:0] o_rx_byte,
    output logic                                 o_done
);
    import mu_periph_pkg::*;

    localparam int DIV_W  = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;
    localparam int EDGES  = 2 * SPI_BYTE_W;
    localparam int EDGE_W = $clog2(EDGES);
    localparam logic [DIV_W-1:0]  DIV_LAST  = DIV_W'(CLKS_PER_HALF_BIT - 1);
    localparam logic [EDGE_W-1:0] EDGE_LAST = EDGE_W'(EDGES - 1);

    logic                  busy;
    logic [DIV_W-1:0]      div_cnt;
    logic [EDGE_W-1:0]     edge_cnt;
    logic [SPI_BYTE_W-1:0] tx_shift;
    logic [SPI_BYTE_W-1:0] rx_shift;
    logic                  half_tick;
    logic                  last_edge;

    // One SCLK edge per half bit while busy
    assign half_tick = busy && (div_cnt == DIV_LAST);
    assign last_edge = half_tick && (edge_cnt == EDGE_LAST);
    assign o_mosi    = tx_shift[SPI_BYTE_W-1];

    // --------------------------------------
    // Divider, edge counter and TX shifter
    // --------------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            tx_shift <= '0;
            o_sclk   <= 1'b0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start && !busy)
            begin
                busy     <= 1'b1;
                div_cnt  <= '0;
                edge_cnt <= '0;
                tx_shift <= i_tx_byte;
            end
            else if (busy)
            begin
                div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
                if (half_tick)
                begin
                    o_sclk   <= ~o_sclk;
                    edge_cnt <= edge_cnt + 1'b1;
                    // Falling edge, next bit out
                    if (o_sclk)
                        tx_shift <= {tx_shift[SPI_BYTE_W-2:0], 1'b0};
                end
                if (last_edge)
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                end
            end
        end
    end

    // Sample on the rising edge, hand the byte over after the last falling one
    always_ff @(posedge clk)
    begin
        if (half_tick && !o_sclk)
            rx_shift <= {rx_shift[SPI_BYTE_W-2:0], i_miso};
        if (last_edge)
            o_rx_byte <= rx_shift;
    end

endmodule

//--- sources.f
hdl/mu_bus_pkg.sv
hdl/mu_periph_pkg.sv
hdl/io_addr_decoder.sv
hdl/spi_byte_master.sv
hdl/os_timer.sv
hdl/io_bus_controller.sv
hdl/memory_unit.sv
dv/memory_unit_checker.sv
dv/tb_memory_unit.sv
